// ==== list.f ====
verilog/sdram_pkg.sv
verilog/sdram_access_decode.sv
verilog/sdram_cmd_sequencer.sv
verilog/sdram_io_regs.sv
verilog/sdram_ctrl_top.sv
test/sdram_chip_model.sv
test/tb_sdram_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_sdram_ctrl \
  -f list.f -o tb_sim || { echo "build failed"; exit 1; }
output="$(./obj_dir/tb_sim 2>&1)"
echo "$output"
echo "$output" | grep -q "Simulation PASSED" && exit 0 || exit 1

// ==== test/sdram_chip_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_chip_model
  import sdram_pkg::*;
(
  input  wire logic       sys_clk,
  input  wire logic       sys_reset,
  input  wire sdram_cmd_t sdram_cmd,
  input  wire bank_t      sdram_ba,
  input  wire row_t       sdram_a,
  input  wire logic       sdram_cke,
  input  wire data_t      dq_out,
  input  wire logic       dq_oe,
  output data_t           dq_in,
  output logic            acc_valid,   // one pulse per READ or WRITE seen
  output host_req_t       acc,         // address as the device decoded it
  output logic            mode_loaded,
  output logic            proto_err
);

  data_t      mem [host_addr_t];       // sparse, unwritten words read 0
  logic [3:0] bank_open = '0;
  row_t       open_row [4];
  int         cyc = 0;
  int         last_pre = -100;
  int         last_ref = -100;
  int         init_step = 0;           // pre all, ref, ref, mode, then done
  logic       rd_pend = 1'b0;
  data_t      rd_word = '0;
  host_addr_t cur_addr;
  sdram_cmd_t cmd;                     // command as seen this edge

  initial begin
    dq_in       = '0;
    acc_valid   = 1'b0;
    acc         = '0;
    mode_loaded = 1'b0;
    proto_err   = 1'b0;
  end

  task automatic protocol_error(input string what);
    $display("sdram model error at cycle %0d: %s", cyc, what);
    proto_err <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // command decode, one pin command per edge
  ////////////////////////////////////////////////////////////
  always @(posedge sys_clk) begin
    cyc = cyc + 1;
    cmd = sys_reset ? CMD_NOP : sdram_cmd;  // pins hold no command until reset loads them
    acc_valid <= 1'b0;
    if (rd_pend)
      dq_in <= rd_word;  // cas 2, word lands one edge after the READ is seen
    rd_pend = 1'b0;
    if (mode_loaded)
      assert (cyc - last_ref <= 1562) else protocol_error("refresh interval exceeded");
    if (cmd != CMD_NOP) begin
      assert (sdram_cke) else protocol_error("command issued while cke low");
      assert (cyc - last_pre >= T_RP_CYCLES)
        else protocol_error("command too soon after precharge");
      assert (cyc - last_ref >= T_RFC_CYCLES)
        else protocol_error("command too soon after refresh");
      if (init_step < 4) begin
        case (init_step)
          0: assert (cmd == CMD_PRECHARGE && sdram_a[10])
               else protocol_error("init does not start with precharge all");
          1, 2: assert (cmd == CMD_REFRESH) else protocol_error("init refresh missing");
          default: assert (cmd == CMD_LOAD_MODE && sdram_a == MODE_REG_VALUE)
                     else protocol_error("mode register load wrong or missing");
        endcase
        init_step = init_step + 1;
      end
    end
    case (cmd)
      CMD_ACTIVE: begin
        assert (!bank_open[sdram_ba]) else protocol_error("activate on an open bank");
        bank_open[sdram_ba] = 1'b1;
        open_row[sdram_ba]  = sdram_a;
      end
      CMD_READ, CMD_WRITE: begin
        assert (bank_open[sdram_ba]) else protocol_error("read or write to a closed bank");
        cur_addr = {open_row[sdram_ba], sdram_ba, sdram_a[7:0]};
        acc_valid <= 1'b1;
        if (cmd == CMD_WRITE) begin
          assert (dq_oe) else protocol_error("write without dq driven");
          mem[cur_addr] = dq_out;
          acc <= '{write: 1'b1, addr: cur_addr, data: dq_out};
        end else begin
          rd_word = mem.exists(cur_addr) ? mem[cur_addr] : 16'h0000;
          rd_pend = 1'b1;
          acc <= '{write: 1'b0, addr: cur_addr, data: rd_word};
        end
      end
      CMD_PRECHARGE: begin
        if (sdram_a[10])
          bank_open = '0;  // a10 high closes every bank
        else
          bank_open[sdram_ba] = 1'b0;
        last_pre = cyc;
      end
      CMD_REFRESH: begin
        assert (bank_open == '0) else protocol_error("refresh with a bank still open");
        last_ref = cyc;
      end
      CMD_LOAD_MODE: mode_loaded <= 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== test/tb_sdram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ctrl
  import sdram_pkg::*;
();

  localparam int          NUM_OPS        = 300;
  localparam int          RESET_CYCLES   = 8;
  localparam int          TIMEOUT_CYCLES = INIT_WAIT_CYCLES + NUM_OPS * 40 + 2000;
  localparam logic [31:0] SEED           = 32'h6c00_0b54;

  logic       sys_clk;
  logic       sys_reset;
  host_req_t  req;
  logic       req_valid;
  logic       credit_return;
  data_t      rd_data;
  logic       rd_valid;
  sdram_cmd_t sdram_cmd;
  bank_t      sdram_ba;
  row_t       sdram_a;
  logic       sdram_cke;
  data_t      dq_out;
  logic       dq_oe;
  data_t      dq_in;
  logic       acc_valid;
  host_req_t  acc;
  logic       mode_loaded;
  logic       proto_err;

  logic [31:0] rng_state;
  data_t       ref_mem [host_addr_t];  // reference memory, updated at issue time
  data_t       exp_rd_q [$];           // read results in request order
  host_req_t   exp_acc_q [$];          // device accesses in request order
  int          reads_done    = 0;
  int          accs_done     = 0;
  int          credits_got   = 0;
  int          credits_spent = 0;
  int          cycle_cnt     = 0;

  sdram_ctrl_top dut_i (
    .sys_clk, .sys_reset, .req, .req_valid, .credit_return, .rd_data, .rd_valid,
    .sdram_cmd, .sdram_ba, .sdram_a, .sdram_cke, .dq_out, .dq_oe, .dq_in
  );

  sdram_chip_model chip_i (
    .sys_clk, .sys_reset, .sdram_cmd, .sdram_ba, .sdram_a, .sdram_cke, .dq_out, .dq_oe,
    .dq_in, .acc_valid, .acc, .mode_loaded, .proto_err
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at cycle %0d", cycle_cnt);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual)
      else report_failure($sformatf("mismatch in %s: expected %0h, actual %0h",
                                    name, expected, actual));
  endtask

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;  // 50 MHz
  end

  ////////////////////////////////////////////////////////////
  // stimulus, one request per credit
  ////////////////////////////////////////////////////////////
  initial begin : stimulus
    logic       is_read;
    bank_t      bank;
    host_addr_t addr;
    data_t      wdata;
    data_t      rd_expected;
    sys_reset = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    rng_state = SEED;
    rd_expected = '0;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    #2 sys_reset = 1'b0;
    for (int i = 0; i < NUM_OPS; i++) begin
      @(posedge sys_clk);
      #2 req_valid = 1'b0;
      while (credits_got == credits_spent) begin  // no credit, no request
        @(posedge sys_clk);
        #2;
      end
      rng_state = xorshift32(rng_state);
      is_read   = (rng_state % 32'd100) < 32'd60;  // 60% reads
      rng_state = xorshift32(rng_state);
      bank      = rng_state[1:0];
      // 4 rows per bank and 8 columns, so hits, closed banks and conflicts mix
      addr      = {bank, 8'h3c, rng_state[3:2], bank, 5'b00000, rng_state[6:4]};
      wdata     = rng_state[31:16];
      if (is_read) begin
        rd_expected = ref_mem.exists(addr) ? ref_mem[addr] : 16'h0000;
        exp_rd_q.push_back(rd_expected);
      end else begin
        ref_mem[addr] = wdata;
      end
      exp_acc_q.push_back('{write: !is_read, addr: addr, data: is_read ? rd_expected : wdata});
      req           = '{write: !is_read, addr: addr, data: wdata};
      req_valid     = 1'b1;
      credits_spent = credits_spent + 1;
    end
    @(posedge sys_clk);
    #2 req_valid = 1'b0;
    while (accs_done < NUM_OPS)
      @(posedge sys_clk);
    repeat (20) @(posedge sys_clk);  // last credit and read result, then stray pulses
    check_value("credit count", 32'(NUM_OPS + 1), 32'(credits_got));
    check_value("read count", 32'(exp_rd_q.size()), 32'(reads_done));
    if (credits_got == NUM_OPS + 1 && reads_done == exp_rd_q.size()) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      report_failure("final credit or read counts are off");
    end
  end

  ////////////////////////////////////////////////////////////
  // response monitor, registered outputs sampled at the edge
  ////////////////////////////////////////////////////////////
  always @(posedge sys_clk) begin
    if (!sys_reset) begin
      assert (!proto_err) else report_failure("sdram model flagged a protocol violation");
      if (credit_return) begin
        assert (mode_loaded) else report_failure("credit returned before the mode load");
        credits_got = credits_got + 1;
        assert (credits_got - credits_spent <= 1)
          else report_failure("host holds more than one credit");
      end
      if (rd_valid) begin
        assert (reads_done < exp_rd_q.size())
          else report_failure("rd_valid with no read outstanding");
        check_value("read data", 32'(exp_rd_q[reads_done]), 32'(rd_data));
        reads_done = reads_done + 1;
      end
      if (acc_valid) begin
        assert (accs_done < exp_acc_q.size())
          else report_failure("device access with no request outstanding");
        check_value("access kind", 32'(exp_acc_q[accs_done].write), 32'(acc.write));
        check_value("access address", 32'(exp_acc_q[accs_done].addr), 32'(acc.addr));
        check_value("access data", 32'(exp_acc_q[accs_done].data), 32'(acc.data));
        accs_done = accs_done + 1;
      end
    end
  end

  always @(posedge sys_clk) begin
    cycle_cnt = cycle_cnt + 1;
    assert (cycle_cnt < TIMEOUT_CYCLES)
      else report_failure($sformatf("timeout, run still busy after %0d cycles", cycle_cnt));
  end

endmodule

`default_nettype wire

// ==== verilog/sdram_access_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_access_decode
  import sdram_pkg::*;
(
  input  wire logic         sys_clk,
  input  wire logic         sys_reset,
  input  wire logic         init_done,
  input  wire host_req_t    req,
  input  wire logic         req_valid,
  input  wire logic         take,
  input  wire row_event_t   row_ev,
  output decoded_req_t      decoded_req,
  output logic              credit_return
);

  host_req_t    slot;        // held request
  logic         slot_full;
  logic         init_done_q; // edge detect for the first credit
  logic [3:0]   bank_open;   // one flag per bank
  row_t         open_row [4];
  bank_t        slot_bank;
  row_t         slot_row;
  access_kind_e kind;

  assign slot_bank = slot.addr[9:8];
  assign slot_row  = slot.addr[21:10];

  // classify against the open row table
  always_comb begin
    if (!bank_open[slot_bank])
      kind = BANK_CLOSED;
    else if (open_row[slot_bank] == slot_row)
      kind = ROW_HIT;
    else
      kind = ROW_CONFLICT;  // sequencer precharges, then it comes back closed
  end

  assign decoded_req = '{valid: slot_full, write: slot.write, row: slot_row,
                         bank: slot_bank, col: slot.addr[7:0], data: slot.data, kind: kind};

  ////////////////////////////////////////////////////////////
  // slot, credits and bank open flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (sys_reset) begin
      slot_full     <= 1'b0;
      init_done_q   <= 1'b0;
      credit_return <= 1'b0;
      bank_open     <= '0;
    end else begin
      init_done_q   <= init_done;
      credit_return <= (init_done && !init_done_q) || take;  // one credit per free slot
      if (take)
        slot_full <= 1'b0;
      else if (req_valid)
        slot_full <= 1'b1;
      if (row_ev.close_all)
        bank_open <= '0;
      else if (row_ev.close_en)
        bank_open[row_ev.close_bank] <= 1'b0;
      if (row_ev.open_en)
        bank_open[row_ev.open_bank] <= 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (req_valid)
      slot <= req;
    if (row_ev.open_en)
      open_row[row_ev.open_bank] <= row_ev.open_row;  // row only matters while flag set
  end

  // host spends its only credit, so the slot must be free
  a_req_into_empty: assert property (@(posedge sys_clk) disable iff (sys_reset)
    req_valid |-> !slot_full);
  a_take_from_full: assert property (@(posedge sys_clk) disable iff (sys_reset)
    take |-> slot_full);

endmodule

`default_nettype wire

// ==== verilog/sdram_cmd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_sequencer
  import sdram_pkg::*;
(
  input  wire logic         sys_clk,
  input  wire logic         sys_reset,
  input  wire decoded_req_t decoded_req,
  output logic              take,
  output row_event_t        row_ev,
  output pin_cmd_t          next_pin,
  output logic              capture,
  output logic              init_done,
  output logic              cke
);

  seq_state_e   state;
  seq_state_e   ret_state;       // where WAIT goes when the count runs out
  logic [15:0]  wait_cnt;
  logic [10:0]  refresh_cnt;
  logic         refresh_pending;
  decoded_req_t op;              // request being executed
  logic         pre_all;         // precharge all banks
  bank_t        pre_bank;
  logic         early_wr;        // row hit write, drive dq a cycle ahead
  logic         wait_done;

  // refresh has priority, a conflict is not taken until its bank is closed
  assign take = (state == IDLE) && !refresh_pending && decoded_req.valid &&
                (decoded_req.kind != ROW_CONFLICT);
  assign early_wr  = take && (decoded_req.kind == ROW_HIT) && decoded_req.write;
  assign wait_done = (state == WAIT) && (wait_cnt == '0);
  assign capture   = (state == READ_WAIT);  // dq_in register holds the word now

  ////////////////////////////////////////////////////////////
  // state machine, timed states go through WAIT
  // a count of N in WAIT puts the next command N+2 cycles later
  ////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (sys_reset) begin
      state           <= INIT_WAIT;
      ret_state       <= INIT_PRECHARGE;
      wait_cnt        <= '0;
      cke             <= 1'b0;
      init_done       <= 1'b0;
      refresh_cnt     <= '0;
      refresh_pending <= 1'b0;
    end else begin
      if (wait_done && ret_state == IDLE)
        init_done <= 1'b1;  // sticky, first exit to IDLE is after mode load
      unique case (state)
        INIT_WAIT: begin
          cke       <= 1'b1;
          wait_cnt  <= 16'(INIT_WAIT_CYCLES);
          ret_state <= INIT_PRECHARGE;
          state     <= WAIT;
        end
        INIT_PRECHARGE: begin
          wait_cnt  <= 16'(T_RP_CYCLES - 2);
          ret_state <= INIT_REFRESH1;
          state     <= WAIT;
        end
        INIT_REFRESH1, INIT_REFRESH2: begin
          wait_cnt  <= 16'(T_RFC_CYCLES - 2);
          ret_state <= (state == INIT_REFRESH1) ? INIT_REFRESH2 : LOAD_MODE;
          state     <= WAIT;
        end
        LOAD_MODE: begin
          wait_cnt  <= 16'(T_MRD_CYCLES - 2);
          ret_state <= IDLE;
          state     <= WAIT;
        end
        IDLE: begin
          if (refresh_pending) begin
            refresh_pending <= 1'b0;
            ret_state       <= REFRESH;    // close everything first
            state           <= PRECHARGE;
          end else if (take) begin
            if (decoded_req.kind == ROW_HIT)
              state <= decoded_req.write ? WRITE : READ;
            else
              state <= ACTIVATE;
          end else if (decoded_req.valid) begin
            ret_state <= IDLE;             // come back and take it as closed
            state     <= PRECHARGE;
          end
        end
        REFRESH: begin
          wait_cnt  <= 16'(T_RFC_CYCLES - 2);
          ret_state <= IDLE;
          state     <= WAIT;
        end
        ACTIVATE: begin
          wait_cnt  <= '0;                 // one spare cycle covers trcd
          ret_state <= op.write ? WRITE : READ;
          state     <= WAIT;
        end
        READ: begin
          wait_cnt  <= 16'(READ_CAPTURE_CYCLES - 2);
          ret_state <= READ_WAIT;
          state     <= WAIT;
        end
        READ_WAIT: state <= IDLE;
        WRITE:     state <= IDLE;
        PRECHARGE: begin
          wait_cnt <= 16'(T_RP_CYCLES - 2);  // ret_state already set in IDLE
          state    <= WAIT;
        end
        WAIT: begin
          if (wait_cnt == '0)
            state <= ret_state;
          else
            wait_cnt <= wait_cnt - 16'd1;
        end
        default: state <= INIT_WAIT;
      endcase
      // free running interval, restarted by the mode load
      if (state == LOAD_MODE) begin
        refresh_cnt     <= '0;
        refresh_pending <= 1'b0;
      end else if (refresh_cnt == 11'(REFRESH_INTERVAL)) begin
        refresh_cnt     <= '0;
        refresh_pending <= 1'b1;  // set wins over the clear in IDLE
      end else begin
        refresh_cnt <= refresh_cnt + 11'd1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (take)
      op <= decoded_req;
    if (state == IDLE) begin
      pre_all  <= refresh_pending;
      pre_bank <= decoded_req.bank;
    end
  end

  ////////////////////////////////////////////////////////////
  // command for the pin registers and row table events
  ////////////////////////////////////////////////////////////
  always_comb begin
    next_pin       = '{cmd: CMD_NOP, ba: '0, addr: '0, data: op.data, drive: 1'b0};
    row_ev         = '0;
    if (early_wr || (wait_done && ret_state == WRITE)) begin
      next_pin.drive = 1'b1;  // bus turns on the cycle before WRITE
      next_pin.data  = early_wr ? decoded_req.data : op.data;
    end
    unique case (state)
      INIT_PRECHARGE: begin
        next_pin.cmd      = CMD_PRECHARGE;
        next_pin.addr[10] = 1'b1;  // a10 selects all banks
        row_ev.close_all  = 1'b1;
      end
      INIT_REFRESH1, INIT_REFRESH2, REFRESH: next_pin.cmd = CMD_REFRESH;
      LOAD_MODE: begin
        next_pin.cmd  = CMD_LOAD_MODE;
        next_pin.addr = MODE_REG_VALUE;
      end
      ACTIVATE: begin
        next_pin.cmd     = CMD_ACTIVE;
        next_pin.ba      = op.bank;
        next_pin.addr    = op.row;
        row_ev.open_en   = 1'b1;
        row_ev.open_bank = op.bank;
        row_ev.open_row  = op.row;
      end
      READ, WRITE: begin
        next_pin.cmd   = (state == READ) ? CMD_READ : CMD_WRITE;
        next_pin.ba    = op.bank;
        next_pin.addr  = {4'b0000, op.col};  // a10 low, no auto precharge
        next_pin.drive = (state == WRITE);
      end
      PRECHARGE: begin
        next_pin.cmd      = CMD_PRECHARGE;
        next_pin.ba       = pre_bank;
        next_pin.addr[10] = pre_all;
        row_ev.close_all  = pre_all;
        row_ev.close_en   = !pre_all;
        row_ev.close_bank = pre_bank;
      end
      default: ;  // NOP in waits, idle and init wait
    endcase
  end

  a_state_legal: assert property (@(posedge sys_clk) disable iff (sys_reset)
    state inside {[INIT_WAIT:WAIT]});

endmodule

`default_nettype wire

// ==== verilog/sdram_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_top
  import sdram_pkg::*;
(
  input  wire logic      sys_clk,
  input  wire logic      sys_reset,
  // host side
  input  wire host_req_t req,
  input  wire logic      req_valid,
  output logic           credit_return,
  output data_t          rd_data,
  output logic           rd_valid,
  // device pins, tristate lives in the board top
  output sdram_cmd_t     sdram_cmd,
  output bank_t          sdram_ba,
  output row_t           sdram_a,
  output logic           sdram_cke,
  output data_t          dq_out,
  output logic           dq_oe,
  input  wire data_t     dq_in
);

  decoded_req_t decoded_req;
  logic         take;
  row_event_t   row_ev;
  pin_cmd_t     next_pin;
  logic         capture;
  logic         init_done;
  logic         cke;

  ////////////////////////////////////////////////////////////
  // request slot -> command sequencer -> pad registers
  ////////////////////////////////////////////////////////////
  sdram_access_decode decode_i (
    .sys_clk, .sys_reset, .init_done, .req, .req_valid, .take, .row_ev,
    .decoded_req, .credit_return
  );

  sdram_cmd_sequencer seq_i (
    .sys_clk, .sys_reset, .decoded_req, .take, .row_ev, .next_pin, .capture,
    .init_done, .cke
  );

  sdram_io_regs io_i (
    .sys_clk, .sys_reset, .next_pin, .cke_in(cke), .capture, .dq_in, .sdram_cmd,
    .sdram_ba, .sdram_a, .sdram_cke, .dq_out, .dq_oe, .rd_data, .rd_valid
  );

endmodule

`default_nettype wire

// ==== verilog/sdram_io_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_io_regs
  import sdram_pkg::*;
(
  input  wire logic     sys_clk,
  input  wire logic     sys_reset,
  input  wire pin_cmd_t next_pin,
  input  wire logic     cke_in,
  input  wire logic     capture,
  input  wire data_t    dq_in,
  output sdram_cmd_t    sdram_cmd,
  output bank_t         sdram_ba,
  output row_t          sdram_a,
  output logic          sdram_cke,
  output data_t         dq_out,
  output logic          dq_oe,
  output data_t         rd_data,
  output logic          rd_valid
);

  data_t dq_in_q;  // pad side input register

  ////////////////////////////////////////////////////////////
  // control pins come out of reset as NOP, cke low, bus off
  ////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (sys_reset) begin
      sdram_cmd <= CMD_NOP;
      sdram_cke <= 1'b0;
      dq_oe     <= 1'b0;
      rd_valid  <= 1'b0;
    end else begin
      sdram_cmd <= next_pin.cmd;
      sdram_cke <= cke_in;
      dq_oe     <= next_pin.drive;
      rd_valid  <= capture;  // one cycle pulse per read
    end
  end

  always_ff @(posedge sys_clk) begin
    sdram_ba <= next_pin.ba;
    sdram_a  <= next_pin.addr;
    dq_out   <= next_pin.data;
    dq_in_q  <= dq_in;           // sampled every cycle
    if (capture)
      rd_data <= dq_in_q;
  end

  // output enable only around a write, no fight with read data
  a_oe_near_write: assert property (@(posedge sys_clk) disable iff (sys_reset)
    dq_oe && (sdram_cmd != CMD_WRITE) |=> sdram_cmd == CMD_WRITE);

endmodule

`default_nettype wire

// ==== verilog/sdram_pkg.sv ====
`default_nettype none

package sdram_pkg;

  ////////////////////////////////////////////////////////////
  // device geometry, 16 bit x 4 banks x 4096 rows x 256 cols
  ////////////////////////////////////////////////////////////
  typedef logic [11:0] row_t;        // row address, also the a pins
  typedef logic [1:0]  bank_t;       // bank select
  typedef logic [7:0]  col_t;        // column address
  typedef logic [21:0] host_addr_t;  // {row, bank, col}
  typedef logic [15:0] data_t;       // one data word
  typedef logic [3:0]  sdram_cmd_t;  // {cs_n, ras_n, cas_n, we_n}

  // command truth table, all strobes active low
  localparam sdram_cmd_t CMD_NOP       = 4'b0111;
  localparam sdram_cmd_t CMD_ACTIVE    = 4'b0011;
  localparam sdram_cmd_t CMD_READ      = 4'b0101;
  localparam sdram_cmd_t CMD_WRITE     = 4'b0100;
  localparam sdram_cmd_t CMD_PRECHARGE = 4'b0010;
  localparam sdram_cmd_t CMD_REFRESH   = 4'b0001;
  localparam sdram_cmd_t CMD_LOAD_MODE = 4'b0000;

  // reserved, burst write, standard op, cas 2, sequential, burst 1
  localparam row_t MODE_REG_VALUE = {2'b00, 1'b0, 2'b00, 3'b010, 1'b0, 3'b000};

  ////////////////////////////////////////////////////////////
  // timing in sys_clk cycles at 100 MHz
  ////////////////////////////////////////////////////////////
  localparam int CAS_LATENCY         = 2;
  localparam int INIT_WAIT_CYCLES    = 10100;  // just over 100 us after power up
  localparam int REFRESH_INTERVAL    = 1530;   // 15.6 us budget minus some slack
  localparam int T_RP_CYCLES         = 2;      // precharge to next command
  localparam int T_RFC_CYCLES        = 7;      // refresh to next command
  localparam int T_MRD_CYCLES        = 2;      // mode load to next command
  localparam int READ_CAPTURE_CYCLES = CAS_LATENCY + 2;  // pin reg + dq_in reg

  typedef enum logic [3:0] {
    INIT_WAIT, INIT_PRECHARGE, INIT_REFRESH1, INIT_REFRESH2, LOAD_MODE,
    IDLE, REFRESH, ACTIVATE, READ, READ_WAIT, WRITE, PRECHARGE, WAIT
  } seq_state_e;

  typedef enum logic [1:0] {ROW_HIT, BANK_CLOSED, ROW_CONFLICT} access_kind_e;

  typedef struct packed {
    logic       write;
    host_addr_t addr;
    data_t      data;
  } host_req_t;

  typedef struct packed {
    logic         valid;
    logic         write;
    row_t         row;
    bank_t        bank;
    col_t         col;
    data_t        data;
    access_kind_e kind;
  } decoded_req_t;

  typedef struct packed {
    logic  open_en;     // activate issued
    bank_t open_bank;
    row_t  open_row;
    logic  close_en;    // single bank precharge issued
    bank_t close_bank;
    logic  close_all;   // precharge all issued
  } row_event_t;

  typedef struct packed {
    sdram_cmd_t cmd;
    bank_t      ba;
    row_t       addr;
    data_t      data;
    logic       drive;  // dq output enable
  } pin_cmd_t;

endpackage

`default_nettype wire
